/* src/if_bus_pkg.sv */
/*
  Instruction memory bus types for the fetch stage.
  The memory accepts every request and answers each one exactly once, in order.
  No ready signal exists; flow control is done by fetch credits.
*/

package if_bus_pkg;

  // Data and address width
  localparam int unsigned XLEN = 32;

  ////////////////////
  // Request channel
  ////////////////////

  // Word aligned fetch request, accepted in the cycle it is valid
  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] addr;
  } fetch_req_t;

  ////////////////////
  // Response channel
  ////////////////////

  // One response per request, at least one cycle after it
  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] rdata;
    logic            err;    // bus error on this word
  } fetch_rsp_t;

endpackage

/* src/if_ctrl_pkg.sv */
/*
  Controller command, target address and pipeline payload types of the fetch stage.
  Only 32-bit aligned fetch is supported; targets have their two low bits dropped.
  Interrupt vectoring uses a 5-bit id on top of a 25-bit mtvec base.
*/

package if_ctrl_pkg;

  localparam int unsigned IRQ_ID_W = 5;
  localparam int unsigned MTVEC_W  = 25;

  ////////////////////
  // PC source select
  ////////////////////

  typedef enum logic [2:0] {
    PC_BOOT     = 3'd0,
    PC_JUMP     = 3'd1,
    PC_BRANCH   = 3'd2,
    PC_MRET     = 3'd3,
    PC_TRAP_EXC = 3'd4,
    PC_TRAP_IRQ = 3'd5
  } pc_mux_e;

  // Command from the controller, sampled every cycle
  typedef struct packed {
    logic                pc_set;   // redirect fetch this cycle
    pc_mux_e             pc_mux;
    logic [IRQ_ID_W-1:0] irq_id;   // vector index for PC_TRAP_IRQ
    logic                halt_if;  // hold IF, nothing goes to ID
    logic                kill_if;  // drop whatever is in IF
  } ctrl_if_t;

  // Candidate redirect addresses
  typedef struct packed {
    logic [if_bus_pkg::XLEN-1:0] boot_addr;
    logic [if_bus_pkg::XLEN-1:0] jump_target;
    logic [if_bus_pkg::XLEN-1:0] branch_target;
    logic [if_bus_pkg::XLEN-1:0] mepc;
    logic [MTVEC_W-1:0]          mtvec_base;
  } pc_targets_t;

  ////////////////////
  // Fetch side state
  ////////////////////

  typedef enum logic {
    FS_IDLE  = 1'b0,
    FS_FETCH = 1'b1
  } fetch_state_e;

  // One prefetched word with its address
  typedef struct packed {
    logic [if_bus_pkg::XLEN-1:0] pc;
    logic [if_bus_pkg::XLEN-1:0] instr;
    logic                        err;
  } fetch_entry_t;

  // IF/ID pipeline payload
  typedef struct packed {
    logic                        valid;
    logic [if_bus_pkg::XLEN-1:0] pc;
    logic [if_bus_pkg::XLEN-1:0] instr;
    logic                        abort_op;  // set for bus errors
  } if_id_t;

endpackage

/* src/fetch_addr_gen.sv */
/*
  Next-PC selection and sequential request issue.
  At most FETCH_DEPTH requests and buffered words exist together; the count is held as credits.
  Nothing is fetched before the first pc_set. Requests leave from a register.
*/
`timescale 1ns/10ps

module fetch_addr_gen #(
  parameter int unsigned FETCH_DEPTH = 3
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  if_ctrl_pkg::ctrl_if_t         ctrl_i,
  input  if_ctrl_pkg::pc_targets_t      targets_i,
  input  logic [1:0]                    credit_ret_i,
  output if_bus_pkg::fetch_req_t        fetch_req_o,
  output logic                          flush_o,
  output logic [if_bus_pkg::XLEN-1:0]   flush_pc_o,
  output logic                          idle_o
);

  localparam int unsigned CNT_W = $clog2(FETCH_DEPTH + 1);

  if_ctrl_pkg::fetch_state_e   state_q;
  logic [if_bus_pkg::XLEN-1:0] target_addr;
  logic [if_bus_pkg::XLEN-1:0] issue_addr;
  logic [if_bus_pkg::XLEN-1:0] fetch_addr_q;
  logic [if_bus_pkg::XLEN-1:0] req_addr_q;
  logic                        req_valid_q;
  logic                        fetching;
  logic                        issue;
  logic [CNT_W-1:0]            credits_q;
  logic [CNT_W-1:0]            credits_avail;

  ////////////////////
  // Target select
  ////////////////////

  always_comb begin
    case (ctrl_i.pc_mux)
      if_ctrl_pkg::PC_BOOT:     target_addr = {targets_i.boot_addr[31:2], 2'b00};
      if_ctrl_pkg::PC_JUMP:     target_addr = {targets_i.jump_target[31:2], 2'b00};
      if_ctrl_pkg::PC_BRANCH:   target_addr = {targets_i.branch_target[31:2], 2'b00};
      if_ctrl_pkg::PC_MRET:     target_addr = {targets_i.mepc[31:2], 2'b00};
      // Exceptions share the base of the vector table
      if_ctrl_pkg::PC_TRAP_EXC: target_addr = {targets_i.mtvec_base, 7'h00};
      // Interrupts are vectored, one word per id
      if_ctrl_pkg::PC_TRAP_IRQ: target_addr = {targets_i.mtvec_base, ctrl_i.irq_id, 2'b00};
      default:                  target_addr = {targets_i.boot_addr[31:2], 2'b00};
    endcase
  end

  // Redirect goes to the buffer in the same cycle
  assign flush_o    = ctrl_i.pc_set;
  assign flush_pc_o = target_addr;

  ////////////////////
  // Credits and issue
  ////////////////////

  // Credits returned this cycle can be spent right away
  assign credits_avail = credits_q + CNT_W'(credit_ret_i);

  // A redirect starts fetching in its own cycle
  assign fetching   = ctrl_i.pc_set || (state_q == if_ctrl_pkg::FS_FETCH);
  assign issue      = fetching && (credits_avail != '0);
  assign issue_addr = ctrl_i.pc_set ? target_addr : fetch_addr_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= if_ctrl_pkg::FS_IDLE;
      credits_q   <= CNT_W'(FETCH_DEPTH);
      req_valid_q <= 1'b0;
    end else begin
      if (ctrl_i.pc_set) begin
        state_q <= if_ctrl_pkg::FS_FETCH;
      end
      credits_q   <= credits_avail - CNT_W'(issue);
      req_valid_q <= issue;
    end
  end

  // Address of the next word and the one on the bus
  always_ff @(posedge clk) begin
    if (issue) begin
      req_addr_q   <= issue_addr;
      fetch_addr_q <= issue_addr + 32'd4;
    end else if (ctrl_i.pc_set) begin
      fetch_addr_q <= target_addr;
    end
  end

  assign fetch_req_o.valid = req_valid_q;
  assign fetch_req_o.addr  = req_addr_q;

  // All credits home means nothing in flight or stored
  assign idle_o = (credits_q == CNT_W'(FETCH_DEPTH));

endmodule

/* src/prefetch_buffer.sv */
/*
  Circular buffer of fetched words with in-flight tracking.
  A flush turns every outstanding request into a discard; late words are dropped.
  Credits go back one per pop, per discarded word and per flushed entry (one per cycle).
*/
`timescale 1ns/10ps

module prefetch_buffer #(
  parameter int unsigned FETCH_DEPTH = 3
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  if_bus_pkg::fetch_req_t        fetch_req_i,
  input  if_bus_pkg::fetch_rsp_t        fetch_rsp_i,
  input  logic                          flush_i,
  input  logic [if_bus_pkg::XLEN-1:0]   flush_pc_i,
  input  logic                          pop_i,
  output logic                          head_valid_o,
  output if_ctrl_pkg::fetch_entry_t     head_o,
  output logic [1:0]                    credit_ret_o,
  output logic                          empty_o
);

  localparam int unsigned CNT_W = $clog2(FETCH_DEPTH + 1);
  localparam int unsigned PTR_W = (FETCH_DEPTH > 1) ? $clog2(FETCH_DEPTH) : 1;

  logic [if_bus_pkg::XLEN-1:0] data_mem [FETCH_DEPTH];
  logic                        err_mem  [FETCH_DEPTH];

  logic [PTR_W-1:0]            wr_ptr_q;
  logic [PTR_W-1:0]            rd_ptr_q;
  logic [CNT_W-1:0]            count_q;
  logic [CNT_W-1:0]            inflight_q;
  logic [CNT_W-1:0]            discard_q;
  logic [CNT_W-1:0]            release_q;
  logic [if_bus_pkg::XLEN-1:0] head_pc_q;
  logic                        store;
  logic                        drop;
  logic                        release_one;

  // Wrap for depths that are not a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    logic [PTR_W-1:0] nxt;
    if (ptr == PTR_W'(FETCH_DEPTH - 1)) begin
      nxt = '0;
    end else begin
      nxt = ptr + 1'b1;
    end
    return nxt;
  endfunction

  ////////////////////
  // Response sorting
  ////////////////////

  // Everything arriving in a flush cycle belongs to the old stream
  assign drop  = fetch_rsp_i.valid && (flush_i || (discard_q != '0));
  assign store = fetch_rsp_i.valid && !drop;

  // Flushed entries hand their credits back one at a time
  assign release_one = (release_q != '0);

  assign credit_ret_o = 2'(pop_i) + 2'(drop) + 2'(release_one);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      inflight_q <= '0;
      discard_q  <= '0;
      release_q  <= '0;
    end else if (flush_i) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      inflight_q <= '0;
      // Old requests, including one on the bus now, are still owed a response
      discard_q  <= discard_q + inflight_q + CNT_W'(fetch_req_i.valid) - CNT_W'(drop);
      release_q  <= release_q - CNT_W'(release_one) + count_q - CNT_W'(pop_i);
    end else begin
      if (store) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop_i) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      count_q    <= count_q + CNT_W'(store) - CNT_W'(pop_i);
      inflight_q <= inflight_q + CNT_W'(fetch_req_i.valid) - CNT_W'(store);
      discard_q  <= discard_q - CNT_W'(drop);
      release_q  <= release_q - CNT_W'(release_one);
    end
  end

  ////////////////////
  // Storage
  ////////////////////

  always_ff @(posedge clk) begin
    if (store) begin
      data_mem[wr_ptr_q] <= fetch_rsp_i.rdata;
      err_mem[wr_ptr_q]  <= fetch_rsp_i.err;
    end
  end

  // PC of the oldest entry
  always_ff @(posedge clk) begin
    if (flush_i) begin
      head_pc_q <= flush_pc_i;
    end else if (pop_i) begin
      head_pc_q <= head_pc_q + 32'd4;
    end
  end

  assign head_valid_o = (count_q != '0);
  assign head_o.pc    = head_pc_q;
  assign head_o.instr = data_mem[rd_ptr_q];
  assign head_o.err   = err_mem[rd_ptr_q];

  // Nothing stored, owed or waiting to be released
  assign empty_o = (count_q == '0) && (inflight_q == '0) &&
                   (discard_q == '0) && (release_q == '0);

endmodule

/* src/if_id_reg.sv */
/*
  IF/ID pipeline register.
  Loads only while ID is ready and holds otherwise.
  Halt and kill keep the head in the buffer and send a bubble.
*/
`timescale 1ns/10ps

module if_id_reg (
  input  logic                       clk,
  input  logic                       rst_n,
  input  if_ctrl_pkg::ctrl_if_t      ctrl_i,
  input  logic                       head_valid_i,
  input  if_ctrl_pkg::fetch_entry_t  head_i,
  input  logic                       id_ready_i,
  output logic                       pop_o,
  output if_ctrl_pkg::if_id_t        if_id_o
);

  logic                      instr_valid;
  logic                      valid_q;
  if_ctrl_pkg::fetch_entry_t payload_q;

  // Head may move on only when it is not halted or killed
  assign instr_valid = head_valid_i && !ctrl_i.halt_if && !ctrl_i.kill_if;

  // Take the head when ID accepts
  assign pop_o = instr_valid && id_ready_i;

  ////////////////////
  // Pipeline register
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (id_ready_i) begin
      valid_q <= instr_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (pop_o) begin
      payload_q <= head_i;
    end
  end

  assign if_id_o.valid    = valid_q;
  assign if_id_o.pc       = payload_q.pc;
  assign if_id_o.instr    = payload_q.instr;
  // Bus error aborts the operation in later stages
  assign if_id_o.abort_op = payload_q.err;

endmodule

/* src/if_stage.sv */
/*
  Instruction fetch stage, 32-bit aligned fetch only.
  FETCH_DEPTH sets buffer size and credit count, valid from 2 to 4.
  The controller is expected to raise kill_if with every pc_set.
*/
`timescale 1ns/10ps

module if_stage #(
  parameter int unsigned FETCH_DEPTH = 3
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  if_ctrl_pkg::ctrl_if_t     ctrl_i,
  input  if_ctrl_pkg::pc_targets_t  targets_i,
  output if_bus_pkg::fetch_req_t    fetch_req_o,
  input  if_bus_pkg::fetch_rsp_t    fetch_rsp_i,
  output if_ctrl_pkg::if_id_t       if_id_o,
  input  logic                      id_ready_i,
  output logic                      if_busy_o
);

  logic                        flush;
  logic [if_bus_pkg::XLEN-1:0] flush_pc;
  logic [1:0]                  credit_ret;
  logic                        idle;
  logic                        empty;
  logic                        head_valid;
  if_ctrl_pkg::fetch_entry_t   head;
  logic                        pop;

  // Request side
  fetch_addr_gen #(
    .FETCH_DEPTH  (FETCH_DEPTH)
  ) u_addr_gen (
    .clk          (clk),
    .rst_n        (rst_n),
    .ctrl_i       (ctrl_i),
    .targets_i    (targets_i),
    .credit_ret_i (credit_ret),
    .fetch_req_o  (fetch_req_o),
    .flush_o      (flush),
    .flush_pc_o   (flush_pc),
    .idle_o       (idle)
  );

  // Response storage
  prefetch_buffer #(
    .FETCH_DEPTH  (FETCH_DEPTH)
  ) u_prefetch (
    .clk          (clk),
    .rst_n        (rst_n),
    .fetch_req_i  (fetch_req_o),
    .fetch_rsp_i  (fetch_rsp_i),
    .flush_i      (flush),
    .flush_pc_i   (flush_pc),
    .pop_i        (pop),
    .head_valid_o (head_valid),
    .head_o       (head),
    .credit_ret_o (credit_ret),
    .empty_o      (empty)
  );

  // Output to decode
  if_id_reg u_if_id (
    .clk          (clk),
    .rst_n        (rst_n),
    .ctrl_i       (ctrl_i),
    .head_valid_i (head_valid),
    .head_i       (head),
    .id_ready_i   (id_ready_i),
    .pop_o        (pop),
    .if_id_o      (if_id_o)
  );

  // Busy while any credit is out or any word is held
  assign if_busy_o = !(idle && empty);

endmodule

/* bench/if_mem_model.sv */
/*
  Behavioural instruction memory for the fetch stage testbench.
  Takes every request and answers it once, in order, one to MAX_LAT cycles later.
  Words inside [ERR_LO, ERR_HI] come back with err set.
*/
`timescale 1ns/10ps

module if_mem_model #(
  parameter int unsigned MAX_LAT  = 4,
  parameter integer      SEED     = 58971,
  parameter logic [31:0] DATA_KEY = 32'h0000_0000,
  parameter logic [31:0] ERR_LO   = 32'h0000_0000,
  parameter logic [31:0] ERR_HI   = 32'h0000_0000
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  if_bus_pkg::fetch_req_t req_i,
  output if_bus_pkg::fetch_rsp_t rsp_o
);

  integer                 seed;
  int unsigned            cycle;
  int unsigned            last_due;
  int unsigned            due;
  logic [31:0]            addr;
  logic [31:0]            addr_q [$];
  int unsigned            due_q  [$];
  if_bus_pkg::fetch_rsp_t rsp_next;

  // Stored word is a scrambled copy of its own address
  function automatic logic [31:0] word_at(input logic [31:0] a);
    logic [31:0] x;
    x = a ^ DATA_KEY;
    return {x[24:0], x[31:25]};
  endfunction

  initial begin
    seed     = SEED;
    cycle    = 0;
    last_due = 0;
    rsp_o    = '0;
  end

  always @(posedge clk) begin
    rsp_next = '0;
    if (rst_n) begin
      cycle = cycle + 1;
      // New request gets a due cycle, never ahead of an older one
      if (req_i.valid) begin
        due = cycle + ($unsigned($random(seed)) % MAX_LAT);
        if (due <= last_due) begin
          due = last_due + 1;
        end
        last_due = due;
        addr_q.push_back(req_i.addr);
        due_q.push_back(due);
      end
      // Oldest request answers once due, at most one per cycle
      if ((due_q.size() > 0) && (due_q[0] <= cycle)) begin
        addr = addr_q.pop_front();
        due_q.delete(0);
        rsp_next.valid = 1'b1;
        rsp_next.rdata = word_at(addr);
        rsp_next.err   = (addr >= ERR_LO) && (addr <= ERR_HI);
      end
    end
    // Drive just after the edge, like the rest of the stimulus
    #1;
    rsp_o = rsp_next;
  end

endmodule

/* bench/if_stage_sva.sv */
/*
  Assertions bound into the fetch stage.
  Assumes one memory response per request, in order.
  The flush check relies on kill_if and id_ready_i being high in every pc_set cycle.
*/
`timescale 1ns/10ps

module if_stage_sva #(
  parameter int unsigned FETCH_DEPTH = 3
) (
  input logic                   clk,
  input logic                   rst_n,
  input if_ctrl_pkg::ctrl_if_t  ctrl_i,
  input if_bus_pkg::fetch_req_t fetch_req_o,
  input if_bus_pkg::fetch_rsp_t fetch_rsp_i,
  input if_ctrl_pkg::if_id_t    if_id_o,
  input logic                   id_ready_i,
  input logic                   if_busy_o
);

  int   outstanding_q;
  logic started_q;

  // Requests seen at the port minus responses seen
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outstanding_q <= 0;
      started_q     <= 1'b0;
    end else begin
      outstanding_q <= outstanding_q + int'(fetch_req_o.valid) - int'(fetch_rsp_i.valid);
      if (ctrl_i.pc_set) begin
        started_q <= 1'b1;
      end
    end
  end

  ////////////////////
  // Credits
  ////////////////////

  a_credit_limit: assert property (@(posedge clk) disable iff (!rst_n)
    outstanding_q <= int'(FETCH_DEPTH))
    else $error("more requests in flight than FETCH_DEPTH");

  // A credit is out while any request waits for its word
  a_busy_in_flight: assert property (@(posedge clk) disable iff (!rst_n)
    (outstanding_q > 0) |-> if_busy_o)
    else $error("if_busy_o low with requests in flight");

  ////////////////////
  // Flush
  ////////////////////

  a_flush_bubble: assert property (@(posedge clk) disable iff (!rst_n)
    (ctrl_i.pc_set && id_ready_i) |=> !if_id_o.valid)
    else $error("IF/ID valid right after a redirect");

  // Quiet until the first redirect
  a_reset_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    !started_q |-> (!fetch_req_o.valid && !if_id_o.valid && !if_busy_o))
    else $error("fetch activity before the first pc_set");

endmodule

bind if_stage if_stage_sva #(
  .FETCH_DEPTH (FETCH_DEPTH)
) u_sva (
  .clk         (clk),
  .rst_n       (rst_n),
  .ctrl_i      (ctrl_i),
  .fetch_req_o (fetch_req_o),
  .fetch_rsp_i (fetch_rsp_i),
  .if_id_o     (if_id_o),
  .id_ready_i  (id_ready_i),
  .if_busy_o   (if_busy_o)
);

/* bench/tb_if_stage.sv */
/*
  Testbench for the fetch stage covering reset, boot, back-pressure, redirects, bus errors and halt.
  Memory latency and ID back-pressure are random with a fixed seed.
*/
`timescale 1ns/10ps

module tb_if_stage;

  localparam int unsigned FETCH_DEPTH = 3;
  localparam int unsigned MAX_LAT     = 4;
  localparam integer      SEED        = 58971;
  localparam logic [31:0] DATA_KEY    = 32'h5A3C_96E1;
  // Words in this range answer with a bus error
  localparam logic [31:0] ERR_LO      = 32'h0000_1020;
  localparam logic [31:0] ERR_HI      = 32'h0000_102C;
  localparam int unsigned N_INSTR     = 16;
  // Boot, back-pressure x2, six half-length redirects and halt in units of N_INSTR
  localparam int unsigned N_TESTS     = 7;
  // Worst cycles per word with ID ready only two cycles in three
  localparam int unsigned WORST_LAT   = (MAX_LAT + 2) * 3;
  localparam int unsigned TIMEOUT     = N_TESTS * N_INSTR * WORST_LAT + 500;

  logic                     clk;
  logic                     rst_n;
  if_ctrl_pkg::ctrl_if_t    ctrl;
  if_ctrl_pkg::pc_targets_t targets;
  if_bus_pkg::fetch_req_t   fetch_req;
  if_bus_pkg::fetch_rsp_t   fetch_rsp;
  if_ctrl_pkg::if_id_t      if_id;
  logic                     id_ready;
  logic                     if_busy;

  integer      seed;
  logic        bp_mode;
  logic        started;
  logic        halt_ready_q;
  logic [31:0] exp_pc;
  logic [31:0] exp_req_addr;
  int          outstanding;
  int unsigned accepted;
  int unsigned aborts_seen;
  int unsigned cycles;
  int unsigned error_count;

  if_stage #(
    .FETCH_DEPTH (FETCH_DEPTH)
  ) uut (
    .clk         (clk),
    .rst_n       (rst_n),
    .ctrl_i      (ctrl),
    .targets_i   (targets),
    .fetch_req_o (fetch_req),
    .fetch_rsp_i (fetch_rsp),
    .if_id_o     (if_id),
    .id_ready_i  (id_ready),
    .if_busy_o   (if_busy)
  );

  if_mem_model #(
    .MAX_LAT  (MAX_LAT),
    .SEED     (SEED),
    .DATA_KEY (DATA_KEY),
    .ERR_LO   (ERR_LO),
    .ERR_HI   (ERR_HI)
  ) u_mem (
    .clk      (clk),
    .rst_n    (rst_n),
    .req_i    (fetch_req),
    .rsp_o    (fetch_rsp)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

  ////////////////////
  // Reference model
  ////////////////////

  // Memory holds the address XOR key rotated left by 7
  function automatic logic [31:0] instr_word(input logic [31:0] pc);
    logic [31:0] x;
    x = pc ^ DATA_KEY;
    return {x[24:0], x[31:25]};
  endfunction

  function automatic if_ctrl_pkg::if_id_t expected_if_id(input logic [31:0] pc);
    if_ctrl_pkg::if_id_t e;
    e.valid    = 1'b1;
    e.pc       = pc;
    e.instr    = instr_word(pc);
    e.abort_op = (pc >= ERR_LO) && (pc <= ERR_HI);
    return e;
  endfunction

  // Address rule for each PC source
  function automatic logic [31:0] redirect_target(input if_ctrl_pkg::ctrl_if_t c,
                                                  input if_ctrl_pkg::pc_targets_t t);
    logic [31:0] addr;
    case (c.pc_mux)
      if_ctrl_pkg::PC_BOOT:     addr = t.boot_addr & 32'hFFFF_FFFC;
      if_ctrl_pkg::PC_JUMP:     addr = t.jump_target & 32'hFFFF_FFFC;
      if_ctrl_pkg::PC_BRANCH:   addr = t.branch_target & 32'hFFFF_FFFC;
      if_ctrl_pkg::PC_MRET:     addr = t.mepc & 32'hFFFF_FFFC;
      if_ctrl_pkg::PC_TRAP_EXC: addr = 32'(t.mtvec_base) << 7;
      if_ctrl_pkg::PC_TRAP_IRQ: addr = (32'(t.mtvec_base) << 7) | (32'(c.irq_id) << 2);
      default:                  addr = 32'hFFFF_FFFF;
    endcase
    return addr;
  endfunction

  ////////////////////
  // Compare tasks
  ////////////////////

  task automatic stop_with_failure(input string line);
    error_count = error_count + 1;
    $display("%s", line);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string msg);
    stop_with_failure($sformatf("mismatch at %0t ns: %s", $time, msg));
  endtask

  // Payload only matters when valid is expected
  task automatic check_if_id(input if_ctrl_pkg::if_id_t got, input if_ctrl_pkg::if_id_t exp,
                             input string what);
    if (got.valid !== exp.valid) begin
      report_mismatch($sformatf("%s valid %0b, expected %0b", what, got.valid, exp.valid));
    end else if (exp.valid &&
                 ({got.pc, got.instr, got.abort_op} !== {exp.pc, exp.instr, exp.abort_op})) begin
      report_mismatch($sformatf("%s pc %h instr %h abort %0b, expected pc %h instr %h abort %0b",
                                what, got.pc, got.instr, got.abort_op,
                                exp.pc, exp.instr, exp.abort_op));
    end
  endtask

  task automatic check_fetch_req(input if_bus_pkg::fetch_req_t got,
                                 input if_bus_pkg::fetch_req_t exp, input string what);
    if (got.valid !== exp.valid) begin
      report_mismatch($sformatf("%s valid %0b, expected %0b", what, got.valid, exp.valid));
    end else if (exp.valid && (got.addr !== exp.addr)) begin
      report_mismatch($sformatf("%s addr %h, expected %h", what, got.addr, exp.addr));
    end
  endtask

  task automatic check_busy(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      report_mismatch($sformatf("%s %0b, expected %0b", what, got, exp));
    end
  endtask

  ////////////////////
  // Checker
  ////////////////////

  always @(posedge clk) begin : compare_proc
    if_bus_pkg::fetch_req_t req_exp;
    logic [31:0]            target;
    if (rst_n) begin
      // Nothing moves before the first redirect
      if (!started) begin
        check_fetch_req(fetch_req, '0, "request before pc_set");
        check_if_id(if_id, '0, "IF/ID before pc_set");
        check_busy(if_busy, 1'b0, "if_busy_o before pc_set");
      end
      // Requests walk the address stream
      if (fetch_req.valid) begin
        req_exp.valid = 1'b1;
        req_exp.addr  = exp_req_addr;
        check_fetch_req(fetch_req, req_exp, "fetch request");
        exp_req_addr = exp_req_addr + 32'd4;
      end
      outstanding = outstanding + int'(fetch_req.valid) - int'(fetch_rsp.valid);
      if (outstanding > int'(FETCH_DEPTH)) begin
        report_mismatch($sformatf("%0d requests in flight, limit %0d", outstanding, FETCH_DEPTH));
      end
      // An unanswered request holds a credit
      if (outstanding > 0) begin
        check_busy(if_busy, 1'b1, "if_busy_o with requests in flight");
      end
      // Halt seen with ID ready last edge gives a bubble now
      if (halt_ready_q) begin
        check_if_id(if_id, '0, "IF/ID during halt");
      end
      if (if_id.valid && id_ready) begin
        check_if_id(if_id, expected_if_id(exp_pc), "delivered instruction");
        exp_pc   = exp_pc + 32'd4;
        accepted = accepted + 1;
        if (if_id.abort_op) begin
          aborts_seen = aborts_seen + 1;
        end
      end
      // Old stream ends at this edge
      if (ctrl.pc_set) begin
        target       = redirect_target(ctrl, targets);
        exp_pc       = target;
        exp_req_addr = target;
      end
      halt_ready_q = ctrl.halt_if && id_ready;
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > TIMEOUT) begin
      stop_with_failure($sformatf("timeout, the tests did not end within %0d cycles", TIMEOUT));
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////

  // Inputs change 1 ns after the edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
    ctrl.pc_set  = 1'b0;
    ctrl.kill_if = 1'b0;
    if (bp_mode) begin
      id_ready = ($unsigned($random(seed)) % 3) != 0;
    end else begin
      id_ready = 1'b1;
    end
  endtask

  // ID stays ready in the pc_set cycle so the bubble is loaded
  task automatic redirect(input if_ctrl_pkg::pc_mux_e mux,
                          input logic [if_ctrl_pkg::IRQ_ID_W-1:0] irq);
    next_cycle();
    ctrl.pc_set  = 1'b1;
    ctrl.pc_mux  = mux;
    ctrl.irq_id  = irq;
    ctrl.kill_if = 1'b1;
    id_ready     = 1'b1;
    started      = 1'b1;
  endtask

  task automatic run_instr(input int unsigned n);
    int unsigned goal;
    goal = accepted + n;
    while (accepted < goal) begin
      next_cycle();
    end
  endtask

  initial begin
    int i;
    seed                  = SEED;
    rst_n                 = 1'b0;
    ctrl                  = '0;
    id_ready              = 1'b0;
    bp_mode               = 1'b0;
    started               = 1'b0;
    halt_ready_q          = 1'b0;
    exp_pc                = '0;
    exp_req_addr          = '0;
    outstanding           = 0;
    accepted              = 0;
    aborts_seen           = 0;
    cycles                = 0;
    error_count           = 0;
    // Boot and mret streams cross the error range
    targets.boot_addr     = 32'h0000_1002;
    targets.jump_target   = 32'h0000_2003;
    targets.branch_target = 32'h0000_3001;
    targets.mepc          = 32'h0000_1016;
    targets.mtvec_base    = 25'h00_0050;
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    repeat (5) next_cycle();
    redirect(if_ctrl_pkg::PC_BOOT, '0);
    run_instr(N_INSTR);
    bp_mode = 1'b1;
    run_instr(2 * N_INSTR);
    // Jump, branch, mret, exception, interrupt and boot with back-pressure on every other one
    for (i = 0; i < 6; i++) begin
      bp_mode = i[0];
      redirect(if_ctrl_pkg::pc_mux_e'((i + 1) % 6), 5'd9);
      run_instr(N_INSTR / 2);
    end
    bp_mode      = 1'b0;
    ctrl.halt_if = 1'b1;
    repeat (8) next_cycle();
    ctrl.halt_if = 1'b0;
    run_instr(N_INSTR);
    if (aborts_seen == 0) begin
      stop_with_failure("no instruction came out with abort_op set");
    end
    if (error_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

/* tb.f */
src/if_bus_pkg.sv
src/if_ctrl_pkg.sv
src/fetch_addr_gen.sv
src/prefetch_buffer.sv
src/if_id_reg.sv
src/if_stage.sv
bench/if_mem_model.sv
bench/if_stage_sva.sv
bench/tb_if_stage.sv

/* Makefile */
# Verilator build of the fetch stage testbench
VERILATOR  := verilator
TOP        := tb_if_stage
FILELIST   := tb.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --assert -Wall -Wno-fatal
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
PASS_MSG   := Everything OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# Pass only when the run prints the pass message
sim:
	$(VERILATOR) $(SIM_FLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
